//--- design/minerPkg.sv
package minerPkg;

	typedef logic [31:0] word_t;
	typedef logic [255:0] digest_t;
	typedef logic [511:0] block_t;
	typedef logic [639:0] header_t;
	typedef logic [31:0] nonce_t;

	typedef enum logic [1:0] {
		ctrlIdle,
		ctrlMidstate,
		ctrlInner,
		ctrlOuter
	} ctrlState_t;

	// first word sits in the top bits.
	localparam digest_t hashInit = {
		32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
	};

	localparam word_t [0:63] roundK = {
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	// block two carries 128 header bits, message length 640.
	localparam logic [383:0] innerPadTail = {1'b1, 319'b0, 64'd640};

	// final block carries the 256-bit first digest.
	localparam logic [255:0] outerPadTail = {1'b1, 191'b0, 64'd256};

endpackage

//--- design/sha256Rounds.sv
`timescale 1ns/100ps

module sha256Rounds (
	input  logic              clock,
	input  logic              rstN,
	input  logic              hashStart,
	input  minerPkg::block_t  hashBlock,
	input  minerPkg::digest_t hashState,
	output logic              hashValid,
	output minerPkg::digest_t hashOut
);

	typedef struct packed {
		minerPkg::word_t a;
		minerPkg::word_t b;
		minerPkg::word_t c;
		minerPkg::word_t d;
		minerPkg::word_t e;
		minerPkg::word_t f;
		minerPkg::word_t g;
		minerPkg::word_t h;
	} workVars_t;

	workVars_t vars;
	workVars_t nextVars;
	minerPkg::word_t window [16]; // schedule words for rounds t to t+15.
	minerPkg::word_t nextWord;
	logic [5:0] round;
	logic running;

	function automatic minerPkg::word_t rotr(input minerPkg::word_t x, input int unsigned n);
		return (x >> n) | (x << (32 - n));
	endfunction

	function automatic minerPkg::word_t smallSigma0(input minerPkg::word_t x);
		return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
	endfunction

	function automatic minerPkg::word_t smallSigma1(input minerPkg::word_t x);
		return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
	endfunction

	function automatic minerPkg::word_t bigSigma0(input minerPkg::word_t x);
		return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
	endfunction

	function automatic minerPkg::word_t bigSigma1(input minerPkg::word_t x);
		return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
	endfunction

	// W[t+16] from the current window.
	assign nextWord = smallSigma1(window[14]) + window[9] + smallSigma0(window[1]) + window[0];

	always_comb begin : roundLogic
		minerPkg::word_t choose;
		minerPkg::word_t majority;
		minerPkg::word_t temp1;
		minerPkg::word_t temp2;

		choose = (vars.e & vars.f) ^ (~vars.e & vars.g);
		majority = (vars.a & vars.b) ^ (vars.a & vars.c) ^ (vars.b & vars.c);
		temp1 = vars.h + bigSigma1(vars.e) + choose + minerPkg::roundK[round] + window[0];
		temp2 = bigSigma0(vars.a) + majority;

		nextVars.h = vars.g;
		nextVars.g = vars.f;
		nextVars.f = vars.e;
		nextVars.e = vars.d + temp1;
		nextVars.d = vars.c;
		nextVars.c = vars.b;
		nextVars.b = vars.a;
		nextVars.a = temp1 + temp2;
	end

	// final addition, read out in the cycle of hashValid.
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			hashOut[255 - 32 * i -: 32] = hashState[255 - 32 * i -: 32] + vars[255 - 32 * i -: 32];
		end
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			running <= 1'b0;
			round <= '0;
			hashValid <= 1'b0;
		end else begin
			hashValid <= 1'b0;
			if (hashStart) begin
				running <= 1'b1;
				round <= '0;
			end else if (running) begin
				round <= round + 6'd1; // wraps back to zero after round 63.
				if (round == 6'd63) begin
					running <= 1'b0;
					hashValid <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (hashStart) begin
			vars <= workVars_t'(hashState);
			for (int i = 0; i < 16; i++) begin
				window[i] <= hashBlock[511 - 32 * i -: 32]; // word zero is the top of the block.
			end
		end else if (running) begin
			vars <= nextVars;
			for (int i = 0; i < 15; i++) begin
				window[i] <= window[i + 1];
			end
			window[15] <= nextWord;
		end
	end

endmodule

//--- design/minerControl.sv
`timescale 1ns/100ps

module minerControl (
	input  logic              clock,
	input  logic              rstN,
	input  logic              start,
	input  minerPkg::header_t blockHeader,
	input  minerPkg::nonce_t  nonceCount,
	input  logic              hashValid,
	input  minerPkg::digest_t hashOut,
	input  logic              hit,
	output logic              hashStart,
	output minerPkg::block_t  hashBlock,
	output minerPkg::digest_t hashState,
	output logic              judgeStrobe,
	output minerPkg::nonce_t  curNonce,
	output logic              jobStart,
	output logic              busy,
	output logic              found,
	output logic              exhausted
);

	minerPkg::ctrlState_t state;
	minerPkg::block_t headBlock; // upper 512 header bits.
	logic [95:0] headTail; // header bits above the nonce in block two.
	minerPkg::nonce_t nonce;
	minerPkg::nonce_t remaining;
	minerPkg::digest_t midstate;
	minerPkg::digest_t firstDigest;
	logic passRequest; // next pass starts on the cycle after hashValid.
	logic accept;

	assign busy = (state != minerPkg::ctrlIdle);
	assign accept = start && !busy;
	assign jobStart = accept;

	// the midstate pass starts in the same cycle as the accepted start.
	assign hashStart = accept || passRequest;
	assign judgeStrobe = hashValid && (state == minerPkg::ctrlOuter);
	assign curNonce = nonce;

	always_comb begin
		hashState = minerPkg::hashInit;
		case (state)
			minerPkg::ctrlIdle: hashBlock = blockHeader[639:128];
			minerPkg::ctrlMidstate: hashBlock = headBlock;
			minerPkg::ctrlInner: begin
				hashBlock = {headTail, nonce, minerPkg::innerPadTail};
				hashState = midstate;
			end
			default: hashBlock = {firstDigest, minerPkg::outerPadTail};
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			state <= minerPkg::ctrlIdle;
			passRequest <= 1'b0;
			found <= 1'b0;
			exhausted <= 1'b0;
		end else begin
			passRequest <= 1'b0;
			found <= 1'b0;
			exhausted <= 1'b0;
			case (state)
				minerPkg::ctrlIdle: begin
					if (accept) state <= minerPkg::ctrlMidstate;
				end
				minerPkg::ctrlMidstate: begin
					if (hashValid) begin
						state <= minerPkg::ctrlInner;
						passRequest <= 1'b1;
					end
				end
				minerPkg::ctrlInner: begin
					if (hashValid) begin
						state <= minerPkg::ctrlOuter;
						passRequest <= 1'b1;
					end
				end
				minerPkg::ctrlOuter: begin
					if (hashValid) begin
						if (hit) begin
							found <= 1'b1;
							state <= minerPkg::ctrlIdle;
						end else if (remaining == 32'd1) begin // last nonce of the range.
							exhausted <= 1'b1;
							state <= minerPkg::ctrlIdle;
						end else begin
							state <= minerPkg::ctrlInner;
							passRequest <= 1'b1;
						end
					end
				end
				default: state <= minerPkg::ctrlIdle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			headBlock <= blockHeader[639:128];
			headTail <= blockHeader[127:32];
			nonce <= blockHeader[31:0];
			remaining <= nonceCount;
		end
		if (hashValid && state == minerPkg::ctrlMidstate) midstate <= hashOut; // once per job.
		if (hashValid && state == minerPkg::ctrlInner) firstDigest <= hashOut;
		if (judgeStrobe && !hit) begin
			nonce <= nonce + 32'd1;
			remaining <= remaining - 32'd1;
		end
	end

endmodule

//--- design/nonceJudge.sv
`timescale 1ns/100ps

module nonceJudge #(
	parameter int unsigned zeroBits = 19
) (
	input  logic              clock,
	input  logic              rstN,
	input  logic              jobStart,
	input  logic              judgeStrobe,
	input  minerPkg::digest_t hashOut,
	input  minerPkg::nonce_t  curNonce,
	output logic              hit,
	output minerPkg::nonce_t  winNonce,
	output minerPkg::digest_t satisfactoryHash
);

	logic leadingZero;

	// top zeroBits of the final digest must all be clear.
	assign leadingZero = (hashOut[255 -: zeroBits] == '0);
	assign hit = judgeStrobe && leadingZero;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			winNonce <= '0;
			satisfactoryHash <= '0;
		end else if (jobStart) begin
			winNonce <= '0; // a new job drops the previous result.
			satisfactoryHash <= '0;
		end else if (hit) begin
			winNonce <= curNonce;
			satisfactoryHash <= hashOut;
		end
	end

endmodule

//--- design/minerTop.sv
`timescale 1ns/100ps

module minerTop #(
	parameter int unsigned zeroBits = 19
) (
	input  logic              clock,
	input  logic              rstN,
	input  logic              start,
	input  minerPkg::header_t blockHeader,
	input  minerPkg::nonce_t  nonceCount,
	output logic              busy,
	output logic              found,
	output logic              exhausted,
	output minerPkg::nonce_t  winNonce,
	output minerPkg::digest_t satisfactoryHash
);

	logic hashStart;
	logic hashValid;
	logic hit;
	logic judgeStrobe;
	logic jobStart;
	minerPkg::block_t hashBlock;
	minerPkg::digest_t hashState;
	minerPkg::digest_t hashOut;
	minerPkg::nonce_t curNonce;

	minerControl control_i (
		.clock(clock),
		.rstN(rstN),
		.start(start),
		.blockHeader(blockHeader),
		.nonceCount(nonceCount),
		.hashValid(hashValid),
		.hashOut(hashOut),
		.hit(hit),
		.hashStart(hashStart),
		.hashBlock(hashBlock),
		.hashState(hashState),
		.judgeStrobe(judgeStrobe),
		.curNonce(curNonce),
		.jobStart(jobStart),
		.busy(busy),
		.found(found),
		.exhausted(exhausted)
	);

	sha256Rounds core_i (
		.clock(clock),
		.rstN(rstN),
		.hashStart(hashStart),
		.hashBlock(hashBlock),
		.hashState(hashState),
		.hashValid(hashValid),
		.hashOut(hashOut)
	);

	nonceJudge #(
		.zeroBits(zeroBits)
	) judge_i (
		.clock(clock),
		.rstN(rstN),
		.jobStart(jobStart),
		.judgeStrobe(judgeStrobe),
		.hashOut(hashOut),
		.curNonce(curNonce),
		.hit(hit),
		.winNonce(winNonce),
		.satisfactoryHash(satisfactoryHash)
	);

endmodule

//--- verification/minerTop_checker.sv
`timescale 1ns/100ps

module minerTop_checker #(
	parameter int unsigned zeroBits = 19
) (
	input logic              clock,
	input logic              rstN,
	input logic              busy,
	input logic              found,
	input logic              exhausted,
	input minerPkg::digest_t satisfactoryHash
);

	int unsigned failures = 0; // failed assertions so far.

	pulseExclusive: assert property (@(posedge clock) disable iff (!rstN)
		!(found && exhausted))
		else begin
			failures++;
			$error("found and exhausted are high together");
		end

	foundOneCycle: assert property (@(posedge clock) disable iff (!rstN) found |=> !found)
		else begin
			failures++;
			$error("found lasted more than one cycle");
		end

	exhaustedOneCycle: assert property (@(posedge clock) disable iff (!rstN)
		exhausted |=> !exhausted)
		else begin
			failures++;
			$error("exhausted lasted more than one cycle");
		end

	// busy drops in the same cycle as the result pulse.
	busyFallsOnPulse: assert property (@(posedge clock) disable iff (!rstN)
		$fell(busy) |-> (found || exhausted))
		else begin
			failures++;
			$error("busy fell without found or exhausted");
		end

	pulseEndsBusy: assert property (@(posedge clock) disable iff (!rstN)
		(found || exhausted) |-> $fell(busy))
		else begin
			failures++;
			$error("result pulse without busy falling");
		end

	hashHasZeros: assert property (@(posedge clock) disable iff (!rstN)
		found |-> (satisfactoryHash[255 -: zeroBits] == '0))
		else begin
			failures++;
			$error("held hash lacks the leading zero bits");
		end

endmodule

//--- verification/minerTb.sv
`timescale 1ns/100ps

module minerTb;

	localparam int unsigned zeroBits = 6;
	localparam int numJobs = 3;

	logic clock;
	logic rstN;
	logic start;
	minerPkg::header_t blockHeader;
	minerPkg::nonce_t nonceCount;
	logic busy;
	logic found;
	logic exhausted;
	minerPkg::nonce_t winNonce;
	minerPkg::digest_t satisfactoryHash;

	int seed = 57;
	int errors = 0;
	int cycle = 0;
	longint limitCycles = 0;
	minerPkg::header_t jobHeader [numJobs];
	minerPkg::nonce_t jobCount [numJobs];
	logic jobInject [numJobs]; // a second start is strobed while the job runs.

	minerTop #(.zeroBits(zeroBits)) minerTop_i (
		.clock(clock),
		.rstN(rstN),
		.start(start),
		.blockHeader(blockHeader),
		.nonceCount(nonceCount),
		.busy(busy),
		.found(found),
		.exhausted(exhausted),
		.winNonce(winNonce),
		.satisfactoryHash(satisfactoryHash)
	);

	bind minerTop minerTop_checker #(.zeroBits(zeroBits)) checker_i (
		.clock(clock),
		.rstN(rstN),
		.busy(busy),
		.found(found),
		.exhausted(exhausted),
		.satisfactoryHash(satisfactoryHash)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	always @(posedge clock) cycle <= cycle + 1;

	function automatic minerPkg::word_t rotateRight(input minerPkg::word_t x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	// reference SHA-256 compression of one block.
	function automatic minerPkg::digest_t compress(input minerPkg::digest_t state,
			input minerPkg::block_t block);
		minerPkg::word_t w [64];
		minerPkg::word_t v [8];
		minerPkg::word_t s0;
		minerPkg::word_t s1;
		minerPkg::word_t t1;
		minerPkg::word_t t2;
		minerPkg::digest_t result;
		for (int t = 0; t < 16; t++)
			w[t] = block[511 - 32 * t -: 32];
		for (int t = 16; t < 64; t++) begin
			s0 = rotateRight(w[t-15], 7) ^ rotateRight(w[t-15], 18) ^ (w[t-15] >> 3);
			s1 = rotateRight(w[t-2], 17) ^ rotateRight(w[t-2], 19) ^ (w[t-2] >> 10);
			w[t] = w[t-16] + s0 + w[t-7] + s1;
		end
		for (int i = 0; i < 8; i++)
			v[i] = state[255 - 32 * i -: 32];
		for (int t = 0; t < 64; t++) begin
			s1 = rotateRight(v[4], 6) ^ rotateRight(v[4], 11) ^ rotateRight(v[4], 25);
			t1 = v[7] + s1 + ((v[4] & v[5]) ^ (~v[4] & v[6])) + minerPkg::roundK[t] + w[t];
			s0 = rotateRight(v[0], 2) ^ rotateRight(v[0], 13) ^ rotateRight(v[0], 22);
			t2 = s0 + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
			for (int i = 7; i > 0; i--)
				v[i] = v[i-1];
			v[4] = v[4] + t1; // v[4] now holds the old d.
			v[0] = t1 + t2;
		end
		for (int i = 0; i < 8; i++)
			result[255 - 32 * i -: 32] = state[255 - 32 * i -: 32] + v[i];
		return result;
	endfunction

	function automatic minerPkg::digest_t doubleHash(input minerPkg::header_t header);
		minerPkg::digest_t mid;
		minerPkg::digest_t first;
		mid = compress(minerPkg::hashInit, header[639:128]);
		first = compress(mid, {header[127:0], minerPkg::innerPadTail});
		return compress(minerPkg::hashInit, {first, minerPkg::outerPadTail});
	endfunction

	// offset of the first qualifying nonce in the range, or -1.
	function automatic longint firstHit(input minerPkg::header_t header,
			input minerPkg::nonce_t count);
		minerPkg::digest_t d;
		for (longint i = 0; i < count; i++) begin
			d = doubleHash({header[639:32], header[31:0] + minerPkg::nonce_t'(i)});
			if (d[255 -: zeroBits] == '0) return i;
		end
		return -1;
	endfunction

	function automatic minerPkg::header_t randomHeader();
		minerPkg::header_t h;
		for (int i = 0; i < 20; i++)
			h[32 * i +: 32] = $random(seed);
		return h;
	endfunction

	task automatic checkValue(input string name, input logic [255:0] expected,
			input logic [255:0] actual);
		assert (actual === expected) else begin
			errors++;
			$display("MISMATCH %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic runJob(input int j);
		longint offset;
		int startCycle;
		minerPkg::nonce_t expNonce;
		string name;
		name = $sformatf("job%0d", j);
		offset = firstHit(jobHeader[j], jobCount[j]);
		@(posedge clock);
		blockHeader <= jobHeader[j];
		nonceCount <= jobCount[j];
		start <= 1'b1;
		@(negedge clock);
		startCycle = cycle; // the cycle in which start is high.
		@(posedge clock);
		start <= 1'b0;
		@(negedge clock);
		checkValue({name, " cleared winNonce"}, 0, winNonce);
		checkValue({name, " cleared hash"}, 0, satisfactoryHash);
		if (jobInject[j]) begin
			repeat (150) @(negedge clock);
			checkValue({name, " busy at second start"}, 1, busy);
			@(posedge clock);
			blockHeader <= randomHeader();
			nonceCount <= 32'd1;
			start <= 1'b1;
			@(posedge clock);
			start <= 1'b0;
		end
		@(negedge clock);
		while (!(found || exhausted))
			@(negedge clock);
		checkValue({name, " cycles to end"},
			66 * (1 + 2 * ((offset < 0) ? jobCount[j] : offset + 1)), cycle - startCycle);
		checkValue({name, " found"}, offset >= 0, found);
		checkValue({name, " exhausted"}, offset < 0, exhausted);
		if (offset >= 0) begin
			expNonce = jobHeader[j][31:0] + minerPkg::nonce_t'(offset);
			checkValue({name, " winNonce"}, expNonce, winNonce);
			checkValue({name, " hash"}, doubleHash({jobHeader[j][639:32], expNonce}),
				satisfactoryHash);
			checkValue({name, " leading zeros"}, 0, satisfactoryHash[255 -: zeroBits]);
		end
	endtask

	task automatic finishRun(input bit timedOut);
		int assertFails;
		assertFails = minerTop_i.checker_i.failures;
		$display("errors: %0d value mismatches, %0d assertion failures", errors, assertFails);
		if (errors == 0 && assertFails == 0 && !timedOut) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	endtask

	initial begin : mainFlow
		longint offset;
		rstN = 1'b0;
		start = 1'b0;
		blockHeader = '0;
		nonceCount = '0;
		// jobs 0 and 2 hit early in their range, job 1 has no hit in its range.
		for (int j = 0; j < numJobs; j++) begin
			do begin
				jobHeader[j] = randomHeader();
				offset = firstHit(jobHeader[j], 200);
			end while ((j == 1) ? (offset >= 0 && offset < 3) : (offset < 0));
			if (j == 1) begin
				jobCount[j] = 3;
			end else begin
				if (offset > 2)
					jobHeader[j][31:0] = jobHeader[j][31:0] + minerPkg::nonce_t'(offset - 2);
				jobCount[j] = 6;
			end
			jobInject[j] = (j != 0);
			limitCycles += 66 * (1 + 2 * jobCount[j]);
		end
		limitCycles += 200;
		fork
			begin
				repeat (limitCycles) @(posedge clock);
				$display("timeout: the jobs did not finish within %0d cycles", limitCycles);
				finishRun(1'b1);
			end
		join_none
		repeat (4) @(posedge clock);
		rstN <= 1'b1;
		@(negedge clock);
		checkValue("reset busy", 0, busy);
		checkValue("reset found", 0, found);
		checkValue("reset exhausted", 0, exhausted);
		checkValue("reset hash", 0, satisfactoryHash);
		for (int j = 0; j < numJobs; j++)
			runJob(j);
		repeat (4) @(posedge clock);
		finishRun(1'b0);
	end

endmodule

//--- minerTop.f
design/minerPkg.sv
design/sha256Rounds.sv
design/minerControl.sv
design/nonceJudge.sv
design/minerTop.sv
verification/minerTop_checker.sv
verification/minerTb.sv

//--- Bender.yml
package:
  name: minerTop

sources:
  - files:
      - design/minerPkg.sv
      - design/sha256Rounds.sv
      - design/minerControl.sv
      - design/nonceJudge.sv
      - design/minerTop.sv
  - target: test
    files:
      - verification/minerTop_checker.sv
      - verification/minerTb.sv
